// File: fxp_div.f
hw/fxp_fmt_pkg.sv
hw/div_pipe_pkg.sv
hw/div_operand_prep.sv
hw/div_core_pipe.sv
hw/div_round_sat.sv
hw/fxp_div_top.sv
testbench/fxp_div_sva.sv
testbench/fxp_div_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the divider testbench with Verilator and run it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BIN=fxp_div_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fxp_div_tb \
	--Mdir "$BUILD_DIR" \
	-o "$BIN" \
	-f fxp_div.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi

// File: testbench/fxp_div_tb.sv
//----------------------------------------
// testbench for the fixed-point divider
// directed table, random pairs, integer
// model, watchdog and closing summary
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fxp_div_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RANDOM     = 200;
	localparam int TABLE_LEN    = 14;
	localparam int LATENCY      = fxp_fmt_pkg::LATENCY;
	localparam int RUN_CYCLES   = RESET_CYCLES + TABLE_LEN + N_RANDOM + LATENCY + 20;
	localparam int WA           = fxp_fmt_pkg::WIIA + fxp_fmt_pkg::WIFA;
	localparam int WB           = fxp_fmt_pkg::WIIB + fxp_fmt_pkg::WIFB;
	localparam int WQ           = fxp_fmt_pkg::WQ;

	typedef struct packed {
		fxp_fmt_pkg::dividend_t a;
		fxp_fmt_pkg::divisor_t  b;
		fxp_fmt_pkg::quotient_t q_rnd;
		logic                   ovf_rnd;
		fxp_fmt_pkg::quotient_t q_trc;
		logic                   ovf_trc;
	} vec_t;

	typedef struct packed {
		logic [31:0] due;
		vec_t        vec;
	} pending_t;

	// dividend, divisor, rounded quotient/overflow, truncated quotient/overflow
	localparam vec_t DIR_TABLE [TABLE_LEN] = '{
		{16'h0600, 16'h0200, 16'h0300, 1'b0, 16'h02FF, 1'b0},
		{16'hFA00, 16'h0200, 16'hFD00, 1'b0, 16'hFD01, 1'b0},
		{16'h0600, 16'hFE00, 16'hFD00, 1'b0, 16'hFD01, 1'b0},
		{16'hFA00, 16'hFE00, 16'h0300, 1'b0, 16'h02FF, 1'b0},
		// 1/3, 2/3, -1/3
		{16'h0100, 16'h0300, 16'h0055, 1'b0, 16'h0055, 1'b0},
		{16'h0200, 16'h0300, 16'h00AB, 1'b0, 16'h00AA, 1'b0},
		{16'hFF00, 16'h0300, 16'hFFAB, 1'b0, 16'hFFAB, 1'b0},
		// 100/0.25 and -100/0.25 out of range
		{16'h6400, 16'h0040, 16'h7FFF, 1'b1, 16'h7FFF, 1'b1},
		{16'h9C00, 16'h0040, 16'h8000, 1'b1, 16'h8000, 1'b1},
		// -64/0.5 is exactly -128.0 and +64/0.5 does not fit
		{16'hC000, 16'h0080, 16'h8000, 1'b0, 16'h8001, 1'b0},
		{16'h4000, 16'h0080, 16'h7FFF, 1'b1, 16'h7FFF, 1'b0},
		// zero divisor
		{16'h0100, 16'h0000, 16'h7FFF, 1'b1, 16'h7FFF, 1'b1},
		{16'hFF00, 16'h0000, 16'h8000, 1'b1, 16'h8000, 1'b1},
		{16'h0000, 16'h0300, 16'h0000, 1'b0, 16'h0000, 1'b0}
	};

	logic                   clk = 1'b0;
	logic                   rstn;
	fxp_fmt_pkg::dividend_t dividend;
	fxp_fmt_pkg::divisor_t  divisor;
	fxp_fmt_pkg::quotient_t quotient;
	fxp_fmt_pkg::quotient_t quotient_trunc;
	logic                   overflow;
	logic                   overflow_trunc;

	pending_t    pend_q [$];
	logic [31:0] rng_state;
	int          quotient_errors = 0;
	int          overflow_errors = 0;
	int          other_errors = 0;

	fxp_div_top #(.ROUND(1)) u_fxp_div_top (
		.clk      (clk),
		.rstn     (rstn),
		.dividend (dividend),
		.divisor  (divisor),
		.quotient (quotient),
		.overflow (overflow)
	);

	// truncating instance on the same inputs
	fxp_div_top #(.ROUND(0)) u_fxp_div_top_trunc (
		.clk      (clk),
		.rstn     (rstn),
		.dividend (dividend),
		.divisor  (divisor),
		.quotient (quotient_trunc),
		.overflow (overflow_trunc)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	//----------------------------------------
	// integer reference model
	//----------------------------------------
	// returns {quotient, overflow}
	function automatic logic [16:0] model_divide(
		input fxp_fmt_pkg::dividend_t a,
		input fxp_fmt_pkg::divisor_t  b,
		input bit                     rnd
	);
		longint                 mag_a;
		longint                 mag_b;
		longint                 n;
		longint                 t;
		longint                 r;
		longint                 q_max;
		logic                   sign;
		fxp_fmt_pkg::quotient_t q;
		logic                   ovf;
		mag_a = a[WA-1] ? (longint'(1) << WA) - longint'(a) : longint'(a);
		mag_b = b[WB-1] ? (longint'(1) << WB) - longint'(b) : longint'(b);
		n = mag_a * (longint'(1) << fxp_fmt_pkg::WOF) * (longint'(1) << fxp_fmt_pkg::WIFB)
			/ (longint'(1) << fxp_fmt_pkg::WIFA);
		q_max = (longint'(1) << WQ) - 1;
		if (n == 0) begin
			t = 0;
		end else if (mag_b == 0) begin
			t = q_max;
		end else begin
			t = (n + mag_b - 1) / mag_b - 1;
			if (t > q_max) begin
				t = q_max;
			end
		end
		r = t;
		if (rnd && t != q_max && 2 * n > (2 * t + 1) * mag_b) begin
			r = t + 1;
		end
		sign = a[WA-1] ^ b[WB-1];
		ovf = 1'b0;
		if (r >= (longint'(1) << (WQ - 1))) begin
			if (sign) begin
				q = {1'b1, {(WQ-1){1'b0}}};
				ovf = (r != (longint'(1) << (WQ - 1)));
			end else begin
				q = {1'b0, {(WQ-1){1'b1}}};
				ovf = 1'b1;
			end
		end else if (sign) begin
			q = fxp_fmt_pkg::quotient_t'(-r);
		end else begin
			q = fxp_fmt_pkg::quotient_t'(r);
		end
		return {q, ovf};
	endfunction

	task automatic next_random_vector(output vec_t v);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [16:0] exp_rnd;
		logic [16:0] exp_trc;
		rng_state = xorshift32(rng_state);
		r1 = rng_state;
		rng_state = xorshift32(rng_state);
		r2 = rng_state;
		// random shift spreads the dividend over small and large values
		v.a = $signed(r1[15:0]) >>> r1[19:16];
		v.b = r2[15:0];
		exp_rnd = model_divide(v.a, v.b, 1'b1);
		exp_trc = model_divide(v.a, v.b, 1'b0);
		v.q_rnd = exp_rnd[16:1];
		v.ovf_rnd = exp_rnd[0];
		v.q_trc = exp_trc[16:1];
		v.ovf_trc = exp_trc[0];
	endtask

	task automatic apply_vector(input vec_t v, input int cycle);
		pending_t p;
		dividend = v.a;
		divisor = v.b;
		p.due = 32'(cycle + LATENCY);
		p.vec = v;
		pend_q.push_back(p);
	endtask

	//----------------------------------------
	// checks
	//----------------------------------------
	task automatic compare_field(
		input string       name,
		input logic [15:0] got,
		input logic [15:0] want,
		input vec_t        v,
		inout int          errs
	);
		assert (got === want) else begin
			errs++;
			$display("Mismatch %s: got %h expected %h (dividend %h divisor %h)",
				name, got, want, v.a, v.b);
		end
	endtask

	task automatic check_result(input pending_t p);
		compare_field("quotient", quotient, p.vec.q_rnd, p.vec, quotient_errors);
		compare_field("overflow", 16'(overflow), 16'(p.vec.ovf_rnd), p.vec, overflow_errors);
		compare_field("quotient_trunc", quotient_trunc, p.vec.q_trc, p.vec, quotient_errors);
		compare_field("overflow_trunc", 16'(overflow_trunc), 16'(p.vec.ovf_trc), p.vec,
			overflow_errors);
	endtask

	// outputs while only zero inputs are in flight
	task automatic check_cleared();
		vec_t idle;
		idle = '0;
		compare_field("quotient", quotient, 16'h0000, idle, other_errors);
		compare_field("overflow", 16'(overflow), 16'h0000, idle, other_errors);
		compare_field("quotient_trunc", quotient_trunc, 16'h0000, idle, other_errors);
		compare_field("overflow_trunc", 16'(overflow_trunc), 16'h0000, idle, other_errors);
	endtask

	//----------------------------------------
	// stimulus and checking, falling edge
	//----------------------------------------
	initial begin
		vec_t     v;
		pending_t p;
		rstn = 1'b0;
		dividend = '0;
		divisor = '0;
		rng_state = 32'd17;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_cleared();
		end
		rstn = 1'b1;
		for (int cycle = 0; cycle < TABLE_LEN + N_RANDOM + LATENCY; cycle++) begin
			@(negedge clk);
			// zero inputs from reset flow through until the first pair
			if (cycle < LATENCY) begin
				check_cleared();
			end
			while (pend_q.size() > 0 && pend_q[0].due == cycle) begin
				p = pend_q.pop_front();
				check_result(p);
			end
			if (cycle < TABLE_LEN) begin
				apply_vector(DIR_TABLE[cycle], cycle);
			end else if (cycle < TABLE_LEN + N_RANDOM) begin
				next_random_vector(v);
				apply_vector(v, cycle);
			end else begin
				dividend = '0;
				divisor = '0;
			end
		end
		assert (pend_q.size() == 0) else begin
			other_errors++;
			$display("%0d results never arrived", pend_q.size());
		end
		$display("errors: quotient %0d, overflow %0d, other %0d",
			quotient_errors, overflow_errors, other_errors);
		if (quotient_errors + overflow_errors + other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(CLK_PERIOD * RUN_CYCLES);
		$display("run timed out after %0d cycles", RUN_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/fxp_div_sva.sv
//----------------------------------------
// assertions on the divider output side
// reset state and saturated overflow values
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fxp_div_sva (
	input wire logic                      clk,
	input wire logic                      rstn,
	input wire logic                      rnd_sign,
	input wire div_pipe_pkg::div_result_t result
);

	localparam int WQ = fxp_fmt_pkg::WQ;

	localparam fxp_fmt_pkg::quotient_t MAX_POS = {1'b0, {(WQ-1){1'b1}}};
	localparam fxp_fmt_pkg::quotient_t MAX_NEG = {1'b1, {(WQ-1){1'b0}}};

	// output register held clear while in reset
	reset_clear: assert property (@(posedge clk) !rstn |-> result == '0)
		else $error("result not zero during reset");

	//----------------------------------------
	// saturation on overflow
	//----------------------------------------
	// sign of the item now in result was in rnd_sign one cycle earlier
	pos_saturate: assert property (@(posedge clk) disable iff (!rstn)
		(result.overflow && !$past(rnd_sign)) |-> result.quotient == MAX_POS)
		else $error("positive overflow without the largest positive quotient");

	neg_saturate: assert property (@(posedge clk) disable iff (!rstn)
		(result.overflow && $past(rnd_sign)) |-> result.quotient == MAX_NEG)
		else $error("negative overflow without the most negative quotient");

endmodule

bind div_round_sat fxp_div_sva u_sva (
	.clk      (clk),
	.rstn     (rstn),
	.rnd_sign (rnd_sign),
	.result   (result)
);

`default_nettype wire

// File: hw/fxp_div_top.sv
//--------------------------------------
// pipelined signed fixed-point divider
// operand prep, division core, rounding
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fxp_div_top #(
	parameter int unsigned ROUND = 1
) (
	input  wire logic                   clk,
	input  wire logic                   rstn,
	input  wire fxp_fmt_pkg::dividend_t dividend,
	input  wire fxp_fmt_pkg::divisor_t  divisor,
	output fxp_fmt_pkg::quotient_t      quotient,
	output logic                        overflow
);

	div_pipe_pkg::prep_t       prep;
	div_pipe_pkg::core_t       core;
	div_pipe_pkg::div_result_t result;

	div_operand_prep u_prep (
		.clk      (clk),
		.rstn     (rstn),
		.dividend (dividend),
		.divisor  (divisor),
		.prep     (prep)
	);

	div_core_pipe u_core (
		.clk  (clk),
		.rstn (rstn),
		.prep (prep),
		.core (core)
	);

	div_round_sat #(
		.ROUND (ROUND)
	) u_round_sat (
		.clk    (clk),
		.rstn   (rstn),
		.core   (core),
		.result (result)
	);

	assign quotient = result.quotient;
	assign overflow = result.overflow;

endmodule

`default_nettype wire

// File: hw/div_round_sat.sv
//--------------------------------------
// divider output side
// round to nearest, then sign restore
// with saturation and overflow flag
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_round_sat #(
	parameter int unsigned ROUND = 1
) (
	input  wire logic                clk,
	input  wire logic                rstn,
	input  wire div_pipe_pkg::core_t core,
	output div_pipe_pkg::div_result_t result
);

	localparam int WQ  = fxp_fmt_pkg::WQ;
	localparam int WOF = fxp_fmt_pkg::WOF;

	localparam fxp_fmt_pkg::quotient_t MAX_POS = {1'b0, {(WQ-1){1'b1}}};
	localparam fxp_fmt_pkg::quotient_t MAX_NEG = {1'b1, {(WQ-1){1'b0}}};

	fxp_fmt_pkg::operand_t  next_mult;
	fxp_fmt_pkg::operand_t  gap_above;
	fxp_fmt_pkg::operand_t  gap_below;
	logic                   round_up;
	fxp_fmt_pkg::quotient_t rnd_quot;
	logic                   rnd_sign;

	//--------------------------------------
	// rounding stage
	//--------------------------------------
	// acc holds t divisor units, next_mult is t+1 of them
	// and never lies below the dividend
	always_comb begin
		next_mult = core.acc + (core.divisor >> WOF);
		gap_above = next_mult - core.dividend;
		gap_below = core.dividend - core.acc;
		round_up  = (ROUND != 0) && !(&core.quotient) && (gap_above < gap_below);
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rnd_quot <= '0;
			rnd_sign <= 1'b0;
		end else begin
			rnd_quot <= round_up ? core.quotient + 1'b1 : core.quotient;
			rnd_sign <= core.sign;
		end
	end

	//--------------------------------------
	// sign and saturation stage
	//--------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			result.overflow <= 1'b0;
			if (rnd_quot[WQ-1]) begin
				if (rnd_sign) begin
					// exactly 2^(WQ-1) is still representable
					result.quotient <= MAX_NEG;
					result.overflow <= |rnd_quot[WQ-2:0];
				end else begin
					result.quotient <= MAX_POS;
					result.overflow <= 1'b1;
				end
			end else if (rnd_sign) begin
				result.quotient <= ~rnd_quot + 1'b1;
			end else begin
				result.quotient <= rnd_quot;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/div_core_pipe.sv
//--------------------------------------
// restoring division pipeline
// one quotient bit per stage, MSB first
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_core_pipe (
	input  wire logic                clk,
	input  wire logic                rstn,
	input  wire div_pipe_pkg::prep_t prep,
	output div_pipe_pkg::core_t      core
);

	localparam int N_STAGES = fxp_fmt_pkg::N_STAGES;
	localparam int WQ       = fxp_fmt_pkg::WQ;
	localparam int WOI      = fxp_fmt_pkg::WOI;

	// stage_in[k] feeds register stage_q[k]
	div_pipe_pkg::core_t stage_in [N_STAGES];
	div_pipe_pkg::core_t stage_q  [N_STAGES];

	genvar k;

	generate
		for (k = 0; k < N_STAGES; k++) begin : g_stage
			fxp_fmt_pkg::operand_t step;
			fxp_fmt_pkg::operand_t trial_sum;
			logic                  take;

			// stage 0 starts from an empty quotient and accumulator
			if (k == 0) begin : g_first
				assign stage_in[k] = '{
					quotient: '0,
					acc:      '0,
					dividend: prep.dividend,
					divisor:  prep.divisor,
					sign:     prep.sign
				};
			end else begin : g_next
				assign stage_in[k] = stage_q[k-1];
			end

			// divisor weighted by the quotient bit this stage decides
			if (k < WOI) begin : g_int_bit
				assign step = stage_in[k].divisor << (WOI - 1 - k);
			end else begin : g_frac_bit
				assign step = stage_in[k].divisor >> (k + 1 - WOI);
			end

			assign trial_sum = stage_in[k].acc + step;

			// strict compare keeps the accumulator below the dividend
			assign take = trial_sum < stage_in[k].dividend;

			always_ff @(posedge clk or negedge rstn) begin
				if (!rstn) begin
					stage_q[k] <= '0;
				end else begin
					stage_q[k] <= stage_in[k];
					stage_q[k].quotient[WQ-1-k] <= take;
					if (take) begin
						stage_q[k].acc <= trial_sum;
					end
				end
			end
		end
	endgenerate

	//--------------------------------------
	// last stage leaves the core
	//--------------------------------------
	assign core = stage_q[N_STAGES-1];

endmodule

`default_nettype wire

// File: hw/div_operand_prep.sv
//--------------------------------------
// divider input stage
// magnitudes, alignment to the internal
// format and result sign, registered
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_operand_prep (
	input  wire logic                   clk,
	input  wire logic                   rstn,
	input  wire fxp_fmt_pkg::dividend_t dividend,
	input  wire fxp_fmt_pkg::divisor_t  divisor,
	output div_pipe_pkg::prep_t         prep
);

	localparam int DIVD_MSB = fxp_fmt_pkg::WIIA + fxp_fmt_pkg::WIFA - 1;
	localparam int DIVR_MSB = fxp_fmt_pkg::WIIB + fxp_fmt_pkg::WIFB - 1;

	// shifts that move each binary point to WRF
	localparam int DIVD_SHIFT = fxp_fmt_pkg::WRF - fxp_fmt_pkg::WIFA;
	localparam int DIVR_SHIFT = fxp_fmt_pkg::WRF - fxp_fmt_pkg::WIFB;

	fxp_fmt_pkg::dividend_t dividend_mag;
	fxp_fmt_pkg::divisor_t  divisor_mag;
	fxp_fmt_pkg::operand_t  dividend_aln;
	fxp_fmt_pkg::operand_t  divisor_aln;
	logic                   res_sign;

	//--------------------------------------
	// magnitudes
	//--------------------------------------
	// the most negative input maps onto 2^(W-1), which is still
	// correct as an unsigned magnitude
	always_comb begin
		if (dividend[DIVD_MSB]) begin
			dividend_mag = ~dividend + 1'b1;
		end else begin
			dividend_mag = dividend;
		end

		if (divisor[DIVR_MSB]) begin
			divisor_mag = ~divisor + 1'b1;
		end else begin
			divisor_mag = divisor;
		end
	end

	// widen only, zero fill on both sides
	always_comb begin
		dividend_aln = fxp_fmt_pkg::operand_t'(dividend_mag) << DIVD_SHIFT;
		divisor_aln  = fxp_fmt_pkg::operand_t'(divisor_mag) << DIVR_SHIFT;
	end

	assign res_sign = dividend[DIVD_MSB] ^ divisor[DIVR_MSB];

	//--------------------------------------
	// first pipeline register
	//--------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			prep <= '0;
		end else begin
			prep.dividend <= dividend_aln;
			prep.divisor  <= divisor_aln;
			prep.sign     <= res_sign;
		end
	end

endmodule

`default_nettype wire

// File: hw/div_pipe_pkg.sv
//--------------------------------------
// records passed between divider stages
// prepared operands, per-stage state and
// the final result
//--------------------------------------
`default_nettype none

package div_pipe_pkg;

	//--------------------------------------
	// input side to first division stage
	//--------------------------------------
	typedef struct packed {
		fxp_fmt_pkg::operand_t dividend;
		fxp_fmt_pkg::operand_t divisor;
		logic                  sign;
	} prep_t;

	//--------------------------------------
	// state carried by each division stage
	//--------------------------------------
	typedef struct packed {
		// quotient bits decided so far
		fxp_fmt_pkg::quotient_t quotient;
		// sum of the accepted divisor multiples
		fxp_fmt_pkg::operand_t  acc;
		fxp_fmt_pkg::operand_t  dividend;
		fxp_fmt_pkg::operand_t  divisor;
		logic                   sign;
	} core_t;

	// signed, saturated quotient
	typedef struct packed {
		fxp_fmt_pkg::quotient_t quotient;
		logic                   overflow;
	} div_result_t;

endpackage

`default_nettype wire

// File: hw/fxp_fmt_pkg.sv
//--------------------------------------
// number formats of the divider
// operand, quotient and internal widths
// plain vector types for each format
//--------------------------------------
`default_nettype none

package fxp_fmt_pkg;

	// dividend Q8.8
	localparam int WIIA = 8;
	localparam int WIFA = 8;

	// divisor Q8.8
	localparam int WIIB = 8;
	localparam int WIFB = 8;

	// quotient Q8.8
	localparam int WOI = 8;
	localparam int WOF = 8;
	localparam int WQ  = WOI + WOF;

	// internal format holds the divisor shifted up by WOI-1
	// as well as the aligned dividend
	localparam int WRI = (WOI + WIIB > WIIA) ? WOI + WIIB : WIIA;
	localparam int WRF = (WOF + WIFB > WIFA) ? WOF + WIFB : WIFA;
	localparam int WR  = WRI + WRF;

	// one quotient bit per stage
	localparam int N_STAGES = WQ;
	// input register, division stages, rounding, saturation
	localparam int LATENCY  = N_STAGES + 3;

	typedef logic [WIIA+WIFA-1:0] dividend_t;
	typedef logic [WIIB+WIFB-1:0] divisor_t;
	typedef logic [WQ-1:0]        quotient_t;
	typedef logic [WR-1:0]        operand_t;

endpackage

`default_nettype wire
